// ==== hdl/stream_axi_write_pkg.sv ====
package stream_axi_write_pkg;

   // Controller states
   typedef enum logic [1:0] {
      IDLE,
      PLAN,
      ADDR,
      DATA
   } wr_state_e;

   // AXI AWBURST / ARBURST encodings
   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10
   } axi_burst_e;

   // A burst must stay inside one 4 KB page
   localparam logic [31:0] BOUNDARY_BYTES = 32'd4096;

   // Full-width beat size code for a given bus width
   function automatic logic [2:0] axi_size_of(input int data_w);
      case (data_w)
         8:       return 3'b000;
         16:      return 3'b001;
         32:      return 3'b010;
         64:      return 3'b011;
         128:     return 3'b100;
         256:     return 3'b101;
         512:     return 3'b110;
         1024:    return 3'b111;
         default: return 3'b000;
      endcase
   endfunction

endpackage

// ==== hdl/burst_planner.sv ====
`timescale 1ns/100ps

module burst_planner #(
   parameter int ADDR_W    = 32,
   parameter int DATA_W    = 32,
   parameter int LEN_W     = 12,
   parameter int MAX_BURST = 16
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [ADDR_W-1:0]          waddr,
   input  logic [LEN_W-1:0]           wlen,
   input  logic                       plan_start,
   input  logic                       burst_accept,
   input  logic                       beat_take,
   output logic [ADDR_W-1:0]          burst_addr,
   output logic [7:0]                 burst_len,
   output logic [DATA_W/8-1:0]        first_strb,
   output logic [DATA_W/8-1:0]        last_strb,
   output logic                       final_burst,
   output logic [LEN_W:0]             words_left,
   output logic [$clog2(DATA_W/8)-1:0] offset
);
   import stream_axi_write_pkg::*;

   localparam int BYTES  = DATA_W / 8;
   localparam int OFF_W  = $clog2(BYTES);
   localparam int CNT_W  = LEN_W + 1;
   localparam int PAGE_W = $clog2(BOUNDARY_BYTES);

   logic [ADDR_W-1:0] addr_q;
   logic [CNT_W-1:0]  beats_left;
   logic [CNT_W-1:0]  words_q;
   logic [OFF_W-1:0]  off_q;
   logic [OFF_W-1:0]  end_q;

   logic [CNT_W-1:0]  req_words;
   logic [CNT_W-1:0]  req_beats;
   logic [OFF_W-1:0]  req_off;
   logic [OFF_W-1:0]  req_end;

   logic [31:0]       left_beats;
   logic [31:0]       bound_beats;
   logic [31:0]       cap_beats;
   logic [31:0]       burst_beats;

   assign req_off   = waddr[OFF_W-1:0];
   assign req_words = (CNT_W'(wlen) + CNT_W'(BYTES - 1)) >> OFF_W;
   assign req_beats = (CNT_W'(wlen) + CNT_W'(req_off) + CNT_W'(BYTES - 1)) >> OFF_W;
   assign req_end   = OFF_W'(CNT_W'(req_off) + CNT_W'(wlen) - CNT_W'(1)); // Lane of last byte

   // Beats that fit before the next page edge
   assign left_beats  = 32'(beats_left);
   assign bound_beats = (BOUNDARY_BYTES - 32'(addr_q[PAGE_W-1:0])) >> OFF_W;
   assign cap_beats   = (left_beats < 32'(MAX_BURST)) ? left_beats : 32'(MAX_BURST);
   assign burst_beats = (bound_beats < cap_beats) ? bound_beats : cap_beats;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         addr_q     <= '0;
         beats_left <= '0;
         off_q      <= '0;
         end_q      <= '0;
      end else if (plan_start) begin
         addr_q     <= {waddr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
         beats_left <= req_beats;
         off_q      <= req_off;
         end_q      <= req_end;
      end else if (burst_accept) begin
         addr_q     <= addr_q + ADDR_W'(burst_beats << OFF_W);
         beats_left <= beats_left - CNT_W'(burst_beats);
      end
   end

   // Client words still to come, saturates on flush beats
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         words_q <= '0;
      end else if (plan_start) begin
         words_q <= req_words;
      end else if (beat_take && words_q != '0) begin
         words_q <= words_q - CNT_W'(1);
      end
   end

   assign burst_addr  = addr_q;
   assign burst_len   = 8'(burst_beats - 32'd1);
   assign final_burst = (burst_beats == left_beats);
   assign words_left  = words_q;
   assign offset      = off_q;

   assign first_strb = {BYTES{1'b1}} << off_q;
   assign last_strb  = {BYTES{1'b1}} >> (~end_q); // ~end_q is BYTES-1-end_q

endmodule

// ==== hdl/burst_split.sv ====
`timescale 1ns/100ps

module burst_split #(
   parameter int DATA_W = 32
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [$clog2(DATA_W/8)-1:0] offset,
   input  logic [DATA_W-1:0]           wdata,
   input  logic                        beat_take,
   input  logic                        flush,
   output logic [DATA_W-1:0]           data_o
);

   localparam int OFF_W = $clog2(DATA_W / 8);
   localparam int SH_W  = OFF_W + 4;

   logic [SH_W-1:0]   up_sh;
   logic [SH_W-1:0]   dn_sh;
   logic [DATA_W-1:0] shifted;
   logic [DATA_W-1:0] carry;
   logic [DATA_W-1:0] rem_q;

   // Bit shifts for the low and high part of each word
   assign up_sh = SH_W'({offset, 3'b000});
   assign dn_sh = SH_W'(DATA_W) - up_sh;

   assign shifted = wdata << up_sh;
   assign carry   = wdata >> dn_sh;   // Zero when offset is zero

   // Bytes that spill past the top lane wait for the next beat
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rem_q <= '0;
      end else if (beat_take) begin
         if (flush)
            rem_q <= '0;              // Transfer start or flush beat done
         else
            rem_q <= carry;
      end
   end

   assign data_o = flush ? rem_q : (shifted | rem_q);

endmodule

// ==== hdl/axi_write_ctrl.sv ====
`timescale 1ns/100ps

module axi_write_ctrl #(
   parameter int DATA_W = 32,
   parameter int LEN_W  = 12
) (
   input  logic                clk,
   input  logic                rst,
   // Client strobes
   input  logic                wvalid,
   output logic                wready,
   output logic                wlast,
   // AXI handshakes
   input  logic                awready,
   input  logic                wready_i,
   output logic                awvalid,
   output logic                wvalid_o,
   output logic                wlast_o,
   output logic [DATA_W/8-1:0] wstrb,
   // Planner
   input  logic [7:0]          burst_len,
   input  logic [DATA_W/8-1:0] first_strb,
   input  logic [DATA_W/8-1:0] last_strb,
   input  logic                final_burst,
   input  logic [LEN_W:0]      words_left,
   output logic                plan_start,
   output logic                burst_accept,
   // Splitter
   output logic                beat_take,
   output logic                flush
);
   import stream_axi_write_pkg::*;

   localparam int CNT_W = LEN_W + 1;

   wr_state_e  state;
   logic       awvalid_q;
   logic [7:0] beat_cnt;
   logic [7:0] cur_len;
   logic       cur_final;
   logic       first_beat;

   logic       in_data;
   logic       w_hs;
   logic       final_beat;
   logic       exhausted;

   assign in_data    = (state == DATA);
   assign exhausted  = (words_left == '0);
   assign final_beat = cur_final && (beat_cnt == cur_len);
   assign w_hs       = wvalid_o && wready_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= IDLE;
         awvalid_q  <= 1'b0;
         beat_cnt   <= '0;
         cur_len    <= '0;
         cur_final  <= 1'b0;
         first_beat <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (wvalid) begin
                  first_beat <= 1'b1;
                  state      <= PLAN;
               end
            end
            PLAN: begin  // Planner outputs settle here
               awvalid_q <= 1'b1;
               state     <= ADDR;
            end
            ADDR: begin
               if (awready) begin
                  awvalid_q <= 1'b0;
                  cur_len   <= burst_len;   // Planner moves on to next burst
                  cur_final <= final_burst;
                  beat_cnt  <= '0;
                  state     <= DATA;
               end
            end
            DATA: begin
               if (w_hs) begin
                  first_beat <= 1'b0;
                  beat_cnt   <= beat_cnt + 8'd1;
                  if (wlast_o) begin
                     beat_cnt <= '0;
                     state    <= cur_final ? IDLE : PLAN;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assign awvalid      = awvalid_q;
   assign plan_start   = (state == IDLE) && wvalid;
   assign burst_accept = (state == ADDR) && awvalid_q && awready;

   // Flush level also clears the splitter at transfer start
   assign flush = exhausted && (in_data || state == IDLE);

   // One output beat per client word, plus a trailing flush beat if needed
   assign wvalid_o = in_data && (wvalid || exhausted);
   assign wlast_o  = in_data && (beat_cnt == cur_len);
   assign wready   = in_data && !exhausted && wready_i;
   assign wlast    = in_data && (words_left == CNT_W'(1));

   assign beat_take = (in_data && w_hs) || plan_start;

   always_comb begin
      wstrb = '1;
      if (first_beat && final_beat)
         wstrb = first_strb & last_strb;   // Single-beat transfer
      else if (first_beat)
         wstrb = first_strb;
      else if (final_beat)
         wstrb = last_strb;
   end

endmodule

// ==== hdl/stream_axi_write.sv ====
`timescale 1ns/100ps

module stream_axi_write #(
   parameter int ADDR_W    = 32,
   parameter int DATA_W    = 32,
   parameter int LEN_W     = 12,
   parameter int MAX_BURST = 16
) (
   input  logic                clk,
   input  logic                rst,
   // Client stream
   input  logic                wvalid,
   output logic                wready,
   input  logic [ADDR_W-1:0]   waddr,
   input  logic [DATA_W-1:0]   wdata,
   input  logic [LEN_W-1:0]    wlen,
   output logic                wlast,
   // AXI write address
   output logic [ADDR_W-1:0]   awaddr,
   output logic [7:0]          awlen,
   output logic [2:0]          awsize,
   output logic [1:0]          awburst,
   output logic                awvalid,
   input  logic                awready,
   // AXI write data
   output logic [DATA_W-1:0]   wdata_o,
   output logic [DATA_W/8-1:0] wstrb,
   output logic                wlast_o,
   output logic                wvalid_o,
   input  logic                wready_i,
   // AXI write response
   input  logic                bvalid,
   output logic                bready
);
   import stream_axi_write_pkg::*;

   localparam int OFF_W = $clog2(DATA_W / 8);

   logic                plan_start;
   logic                burst_accept;
   logic                beat_take;
   logic                flush;
   logic [7:0]          burst_len;
   logic [DATA_W/8-1:0] first_strb;
   logic [DATA_W/8-1:0] last_strb;
   logic                final_burst;
   logic [LEN_W:0]      words_left;
   logic [OFF_W-1:0]    offset;

   axi_write_ctrl #(
      .DATA_W (DATA_W),
      .LEN_W  (LEN_W)
   ) u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .wvalid       (wvalid),
      .wready       (wready),
      .wlast        (wlast),
      .awready      (awready),
      .wready_i     (wready_i),
      .awvalid      (awvalid),
      .wvalid_o     (wvalid_o),
      .wlast_o      (wlast_o),
      .wstrb        (wstrb),
      .burst_len    (burst_len),
      .first_strb   (first_strb),
      .last_strb    (last_strb),
      .final_burst  (final_burst),
      .words_left   (words_left),
      .plan_start   (plan_start),
      .burst_accept (burst_accept),
      .beat_take    (beat_take),
      .flush        (flush)
   );

   burst_planner #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .LEN_W     (LEN_W),
      .MAX_BURST (MAX_BURST)
   ) u_planner (
      .clk          (clk),
      .rst          (rst),
      .waddr        (waddr),
      .wlen         (wlen),
      .plan_start   (plan_start),
      .burst_accept (burst_accept),
      .beat_take    (beat_take),
      .burst_addr   (awaddr),
      .burst_len    (burst_len),
      .first_strb   (first_strb),
      .last_strb    (last_strb),
      .final_burst  (final_burst),
      .words_left   (words_left),
      .offset       (offset)
   );

   burst_split #(
      .DATA_W (DATA_W)
   ) u_split (
      .clk       (clk),
      .rst       (rst),
      .offset    (offset),
      .wdata     (wdata),
      .beat_take (beat_take),
      .flush     (flush),
      .data_o    (wdata_o)
   );

   assign awlen   = burst_len;
   assign awsize  = axi_size_of(DATA_W);
   assign awburst = INCR;

   // Response is always accepted and otherwise ignored
   assign bready = 1'b1;

endmodule

// ==== tests/axi_wr_asserts.sv ====
`timescale 1ns/100ps

module axi_wr_asserts (
   input logic                            clk,
   input logic                            rst,
   input stream_axi_write_pkg::wr_state_e state,
   input logic                            awvalid,
   input logic                            awready,
   input logic                            wvalid_o,
   input logic                            wready_i,
   input logic                            wlast_o
);
   import stream_axi_write_pkg::*;

   int fails = 0;

   aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
      else begin
         fails++;
         $error("awvalid dropped before awready");
      end

   w_hold: assert property (@(posedge clk) disable iff (rst) wvalid_o && !wready_i |=> wvalid_o)
      else begin
         fails++;
         $error("wvalid_o dropped before wready_i");
      end

   last_in_data: assert property (@(posedge clk) disable iff (rst) wlast_o |-> state == DATA)
      else begin
         fails++;
         $error("wlast_o high outside the DATA state");
      end

   idle_quiet: assert property (@(posedge clk) disable iff (rst) state == IDLE |-> !wvalid_o)
      else begin
         fails++;
         $error("wvalid_o high in IDLE");
      end

endmodule

bind axi_write_ctrl axi_wr_asserts u_asserts (.*);

// ==== tests/axi_wr_checker.sv ====
`timescale 1ns/100ps

module axi_wr_checker #(
   parameter int ADDR_W    = 32,
   parameter int DATA_W    = 32,
   parameter int LEN_W     = 12,
   parameter int MAX_BURST = 16
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                wvalid,
   input  logic                wready,
   input  logic [ADDR_W-1:0]   waddr,
   input  logic [DATA_W-1:0]   wdata,
   input  logic [LEN_W-1:0]    wlen,
   input  logic                wlast,
   input  logic [ADDR_W-1:0]   awaddr,
   input  logic [7:0]          awlen,
   input  logic [2:0]          awsize,
   input  logic [1:0]          awburst,
   input  logic                awvalid,
   input  logic                awready,
   input  logic [DATA_W-1:0]   wdata_o,
   input  logic [DATA_W/8-1:0] wstrb,
   input  logic                wlast_o,
   input  logic                wvalid_o,
   input  logic                wready_i,
   input  logic                bready,
   output int                  errors,
   output logic                busy
);
   localparam int BYTES = DATA_W / 8;

   longint     req_addr;
   longint     next_addr;   // Start of the next burst
   longint     beat_addr;
   int         req_len;
   int         words;
   int         beats;
   int         words_seen;
   int         beats_seen;
   int         pushed;
   int         burst_beats;   // Zero when no burst is open
   int         burst_beat;
   longint     exp_addr[$];
   logic [7:0] exp_byte[$];
   longint     img_addr[$];   // Request bytes still to be found in slave memory
   logic [7:0] img_byte[$];

   initial begin
      errors = 0;
      busy   = 1'b0;
   end

   task automatic report_mismatch(input string name, input longint expected,
                                  input longint actual);
      $display("mismatch at %0t: %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
      errors++;
   endtask

   task automatic log_failure(input string what);
      $display("error at %0t: %s", $time, what);
      errors++;
   endtask

   task automatic start_request();
      req_addr    = longint'(waddr);
      req_len     = int'(wlen);
      next_addr   = req_addr - (req_addr % BYTES);
      words       = (req_len + BYTES - 1) / BYTES;
      beats       = (int'(req_addr % BYTES) + req_len + BYTES - 1) / BYTES;
      words_seen  = 0;
      beats_seen  = 0;
      pushed      = 0;
      burst_beats = 0;
      exp_addr.delete();
      exp_byte.delete();
      busy = 1'b1;
   endtask

   // Bytes past wlen in the last word are padding
   task automatic record_word();
      if (words_seen == words) begin
         log_failure("client word accepted after the last one");
      end else begin
         if (wlast !== (words_seen == words - 1))
            report_mismatch("wlast", words_seen == words - 1, wlast);
         for (int i = 0; i < BYTES; i++) begin
            if (pushed < req_len) begin
               exp_addr.push_back(req_addr + pushed);
               exp_byte.push_back(wdata[8*i +: 8]);
               img_addr.push_back(req_addr + pushed);
               img_byte.push_back(wdata[8*i +: 8]);
               pushed++;
            end
         end
         words_seen++;
      end
   endtask

   task automatic check_address();
      if (burst_beats != 0)
         log_failure("burst address accepted before the previous burst ended");
      if (longint'(awaddr) != next_addr)
         report_mismatch("awaddr", next_addr, awaddr);
      if (int'(awlen) + 1 > MAX_BURST)
         log_failure("burst longer than MAX_BURST beats");
      if ((awaddr % 4096) + (awlen + 1) * BYTES > 4096)
         log_failure("burst crosses a 4 KB boundary");
      if (awsize != 3'($clog2(BYTES)))
         report_mismatch("awsize", $clog2(BYTES), awsize);
      if (awburst != 2'b01)
         report_mismatch("awburst", 1, awburst);
      burst_beats = int'(awlen) + 1;
      burst_beat  = 0;
      beat_addr   = longint'(awaddr);
      next_addr   = beat_addr + burst_beats * BYTES;
   endtask

   task automatic check_beat();
      longint     a;
      logic [7:0] d;
      if (burst_beats == 0) begin
         log_failure("write beat with no open burst");
      end else begin
         if (wlast_o !== (burst_beat == burst_beats - 1))
            report_mismatch("wlast_o", burst_beat == burst_beats - 1, wlast_o);
         for (int i = 0; i < BYTES; i++) begin
            if (wstrb[i] && exp_addr.size() == 0) begin
               log_failure("strobe set on a byte outside the request");
            end else if (wstrb[i]) begin
               a = exp_addr.pop_front();
               d = exp_byte.pop_front();
               if (beat_addr + i != a)
                  report_mismatch("byte address", a, beat_addr + i);
               else if (wdata_o[8*i +: 8] != d)
                  report_mismatch("wdata_o", d, wdata_o[8*i +: 8]);
            end
         end
         beat_addr += BYTES;
         beats_seen++;
         burst_beat++;
         if (burst_beat == burst_beats)
            burst_beats = 0;
         if (beats_seen == beats) begin   // Transfer complete
            if (burst_beats != 0)
               log_failure("transfer ended inside a burst");
            if (words_seen != words)
               report_mismatch("client words", words, words_seen);
            if (exp_addr.size() != 0)
               log_failure("some bytes of the request were never written");
            busy = 1'b0;
         end
      end
   endtask

   // Slave memory one cycle after the last beat of a transfer
   task automatic check_memory();
      longint     a;
      logic [7:0] d;
      while (img_addr.size() != 0) begin
         a = img_addr.pop_front();
         d = img_byte.pop_front();
         if (tb_stream_axi_write.mem[int'(a)] !== d)
            report_mismatch($sformatf("mem[0x%0h]", a), d, tb_stream_axi_write.mem[int'(a)]);
      end
   endtask

   always @(posedge clk) begin
      if (!rst && bready !== 1'b1)
         report_mismatch("bready", 1, bready);
      if (rst) begin
         busy = 1'b0;
      end else if (!busy) begin
         if (img_addr.size() != 0)
            check_memory();
         if (awvalid || wvalid_o || wready)
            log_failure("handshake signals active while no request is open");
         if (wvalid)
            start_request();
      end else begin
         if (wvalid && wready)
            record_word();
         if (awvalid && awready)
            check_address();
         if (wvalid_o && wready_i)
            check_beat();
      end
   end

endmodule

// ==== tests/tb_stream_axi_write.sv ====
`timescale 1ns/100ps

module tb_stream_axi_write;
   localparam int     ADDR_W    = 32;
   localparam int     DATA_W    = 32;
   localparam int     LEN_W     = 12;
   localparam int     MAX_BURST = 16;
   localparam int     BYTES     = DATA_W / 8;
   localparam int     REQUESTS  = 200;
   localparam int     PERIOD    = 4;
   localparam int     MEM_BYTES = 16384 + 512;
   localparam longint WATCHDOG  = longint'(REQUESTS) * 400 * PERIOD;

   logic                clk;
   logic                rst;
   logic                wvalid;
   logic                wready;
   logic [ADDR_W-1:0]   waddr;
   logic [DATA_W-1:0]   wdata;
   logic [LEN_W-1:0]    wlen;
   logic                wlast;
   logic [ADDR_W-1:0]   awaddr;
   logic [7:0]          awlen;
   logic [2:0]          awsize;
   logic [1:0]          awburst;
   logic                awvalid;
   logic                awready;
   logic [DATA_W-1:0]   wdata_o;
   logic [DATA_W/8-1:0] wstrb;
   logic                wlast_o;
   logic                wvalid_o;
   logic                wready_i;
   logic                bvalid;
   logic                bready;
   int                  errors;
   logic                busy;
   logic [ADDR_W-1:0]   slave_addr;
   logic                resp_due;
   logic [7:0]          mem [MEM_BYTES];

   stream_axi_write #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .LEN_W     (LEN_W),
      .MAX_BURST (MAX_BURST)
   ) u_dut (.*);

   axi_wr_checker #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .LEN_W     (LEN_W),
      .MAX_BURST (MAX_BURST)
   ) u_chk (.*);

   function automatic logic [7:0] fill_byte(input int a);
      return 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
   endfunction

   function automatic logic [DATA_W-1:0] random_word();
      logic [DATA_W-1:0] w;
      for (int i = 0; i < DATA_W; i += 32)
         w[i +: 32] = $urandom;
      return w;
   endfunction

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      for (int a = 0; a < MEM_BYTES; a++)
         mem[a] = fill_byte(a);
   end

   // Slave memory, only strobed lanes land
   always @(posedge clk) begin
      if (!rst) begin
         if (awvalid && awready)
            slave_addr = awaddr;
         if (wvalid_o && wready_i) begin
            for (int i = 0; i < BYTES; i++) begin
               if (wstrb[i])
                  mem[(int'(slave_addr) + i) % MEM_BYTES] = wdata_o[8*i +: 8];
            end
            slave_addr = slave_addr + ADDR_W'(BYTES);
            resp_due   = resp_due | wlast_o;
         end
      end
   end

   task automatic drive_ready();
      forever begin
         @(negedge clk);
         awready  = ($urandom_range(99) < 70);
         wready_i = ($urandom_range(99) < 70);
         bvalid   = resp_due;   // One response per burst
         resp_due = 1'b0;
      end
   endtask

   task automatic run_request(input logic [ADDR_W-1:0] addr, input int len);
      int   words;
      int   sent;
      logic taken;
      words = (len + BYTES - 1) / BYTES;
      sent  = 0;
      taken = 1'b0;
      @(negedge clk);
      waddr = addr;
      wlen  = LEN_W'(len);
      while (sent < words) begin
         if (taken)
            wvalid = 1'b0;
         if (!wvalid && $urandom_range(3) != 0) begin   // Else a gap cycle
            wvalid = 1'b1;
            wdata  = random_word();
         end
         @(posedge clk);
         taken = wvalid && wready;
         if (taken)
            sent++;
         @(negedge clk);
      end
      wvalid = 1'b0;
      while (busy)
         @(negedge clk);
      repeat ($urandom_range(3)) @(negedge clk);
   endtask

   initial begin
      #(WATCHDOG);
      $display("Timeout: requests still open after %0d ns", WATCHDOG);
      $display("Regression failed");
      $finish;
   end

   initial begin
      void'($urandom(32'hf786));
      rst      = 1'b1;
      wvalid   = 1'b0;
      waddr    = '0;
      wdata    = '0;
      wlen     = '0;
      awready  = 1'b0;
      wready_i = 1'b0;
      bvalid   = 1'b0;
      resp_due = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      fork
         drive_ready();
      join_none
      for (int n = 0; n < REQUESTS; n++)
         run_request($urandom_range(16383), $urandom_range(300, 1));
      repeat (4) @(negedge clk);
      $display("Checks done: %0d checker errors, %0d assertion failures",
               errors, u_dut.u_ctrl.u_asserts.fails);
      if (errors == 0 && u_dut.u_ctrl.u_asserts.fails == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// ==== stream_axi_write.f ====
hdl/stream_axi_write_pkg.sv
hdl/burst_planner.sv
hdl/burst_split.sv
hdl/axi_write_ctrl.sv
hdl/stream_axi_write.sv
tests/axi_wr_asserts.sv
tests/axi_wr_checker.sv
tests/tb_stream_axi_write.sv
